/* project.f */
verilog/vga_scan_pkg.sv
verilog/line_ram.sv
verilog/line_store.sv
verilog/scan_timing_table.sv
verilog/scan_counter.sv
verilog/sync_decoder.sv
verilog/vga_scan_doubler.sv
test/tb_vga_scan_doubler.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_vga_scan_doubler
RTL_TOP   ?= vga_scan_doubler
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_vga_scan_doubler.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_scan_doubler;
    import vga_scan_pkg::*;

    localparam int CLK_NS         = 4;
    localparam int PAL_FRAME_CLKS = (2 * 312) * (2 * 504); // doubled PAL frame at step 1
    localparam longint WATCHDOG_NS = 64'd8 * PAL_FRAME_CLKS * CLK_NS; // about 8 frames

    logic       clk_dot4x;
    logic       rst;
    logic [3:0] dot_rising;
    raster_x_t  raster_x;
    raster_y_t  raster_y;
    logic [3:0] pixel_in;
    logic       native_x, native_y;
    chip_t      chip;
    logic       hpolarity, vpolarity, enable_csync;
    logic       hsync, vsync, active, half_bright;
    logic [3:0] pixel_out;

    int         errors;
    int         checks;
    logic [7:0] lfsr;     // polarity picker state
    logic [1:0] sub;      // clock within a native dot
    logic       rst_seen; // rst as the DUT saw it at this edge

    vga_scan_doubler #(.COLOR_WIDTH(4)) u_dut (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .dot_rising   (dot_rising),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .pixel_in     (pixel_in),
        .native_x     (native_x),
        .native_y     (native_y),
        .chip         (chip),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .pixel_out    (pixel_out),
        .half_bright  (half_bright)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(CLK_NS / 2) clk_dot4x = ~clk_dot4x;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a test is stuck", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    // native chip geometry, one dot = 4 clocks
    function automatic int native_width(input chip_t c);
        case (c)
            chip_6567r8:   return 520;
            chip_6567r56a: return 512;
            default:       return 504; // both PAL parts
        endcase
    endfunction

    function automatic int native_height(input chip_t c);
        case (c)
            chip_6567r8:   return 263;
            chip_6567r56a: return 262;
            default:       return 312;
        endcase
    endfunction

    // native raster: x steps every 4 clocks, one-hot dot phase rotates
    always @(posedge clk_dot4x) begin
        rst_seen = rst;
        #1;
        if (rst_seen) begin
            raster_x   = '0;
            raster_y   = '0;
            sub        = 2'd0;
            dot_rising = 4'b0001;
        end else begin
            dot_rising = {dot_rising[2:0], dot_rising[3]};
            sub        = sub + 2'd1;
            if (sub == 2'd0) begin
                if (int'(raster_x) == native_width(chip) - 1) begin
                    raster_x = '0;
                    if (int'(raster_y) == native_height(chip) - 1)
                        raster_y = '0;
                    else
                        raster_y = raster_y + 9'd1;
                end else begin
                    raster_x = raster_x + 10'd1;
                end
            end
        end
        pixel_in = raster_y[3:0]; // one color per native line
    end

    // fibonacci lfsr, taps 8 6 5 4, one step per bit
    task automatic rand_bit(output logic b);
        logic fb;
        b    = lfsr[7];
        fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
        lfsr = {lfsr[6:0], fb};
    endtask

    // sync output turned back into an active-high pulse
    function automatic logic sync_pulse(input logic vert);
        if (vert)
            return vpolarity ? vsync : ~vsync;
        return hpolarity ? hsync : ~hsync;
    endfunction

    task automatic check_int(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic restart(input chip_t c, input logic nx, input logic ny, input logic csync);
        @(posedge clk_dot4x);
        #1;
        rst          = 1'b1; // mode is latched while reset holds
        chip         = c;
        native_x     = nx;
        native_y     = ny;
        enable_csync = csync;
        repeat (5) @(posedge clk_dot4x);
        #1;
        rst = 1'b0;
    endtask

    // steps negedges until the pulse rises, clocks counts the steps
    task automatic wait_rise(input logic vert, input int limit, output int clocks);
        logic prev;
        logic cur;
        clocks = 0;
        prev   = sync_pulse(vert);
        cur    = prev;
        while (clocks < limit && !(cur && !prev)) begin
            prev = cur;
            @(negedge clk_dot4x);
            cur = sync_pulse(vert);
            clocks++;
        end
        if (!(cur && !prev)) begin
            errors++;
            $display("no %s pulse started within %0d clocks", vert ? "vsync" : "hsync", limit);
        end
    endtask

    // called on the rise sample, returns on the first low sample
    task automatic pulse_width(input logic vert, output int width);
        width = 0;
        while (sync_pulse(vert) && width < PAL_FRAME_CLKS) begin
            width++;
            @(negedge clk_dot4x);
        end
    endtask

    task automatic measure_line(input int exp_period, input int exp_width, input string tag);
        int k;
        int w;
        wait_rise(1'b0, 3 * exp_period, k);
        pulse_width(1'b0, w);
        check_int({tag, " hsync width"}, w, exp_width);
        checks++;
        if (vsync !== ~vpolarity) begin // these lines are far from the vsync lines
            errors++;
            $display("[ERROR] %0t: %s vsync level %b with polarity %b outside vsync",
                     $time, tag, vsync, vpolarity);
        end
        wait_rise(1'b0, 2 * exp_period, k);
        check_int({tag, " hsync spacing"}, w + k, exp_period);
    endtask

    task automatic hsync_per_chip();
        chip_t c;
        for (int i = 0; i < 4; i++) begin
            c = chip_t'(i);
            restart(c, 1'b0, 1'b0, 1'b0);
            rand_bit(hpolarity);
            rand_bit(vpolarity);
            measure_line(2 * native_width(c), 2 * (70 - 10) + 1, c.name());
        end
        restart(chip_6569r3, 1'b1, 1'b1, 1'b0); // native both axes, step 4
        measure_line(4 * 504, 4 * (70 - 10 + 1), "native pal");
    endtask

    task automatic vsync_per_frame();
        int k;
        int w;
        int line_clks;
        line_clks = 2 * 504;
        restart(chip_6569r3, 1'b0, 1'b0, 1'b0);
        rand_bit(hpolarity);
        rand_bit(vpolarity);
        wait_rise(1'b1, 2 * PAL_FRAME_CLKS, k);
        checks++;
        if (!sync_pulse(1'b0)) begin
            errors++;
            $display("[ERROR] %0t: vsync started away from the hsync start", $time);
        end
        pulse_width(1'b1, w);
        check_int("vsync width", w, (2 * 291 - 2 * 289) * line_clks + (2 * 70 - 2 * 10));
        wait_rise(1'b1, 2 * PAL_FRAME_CLKS, k);
        check_int("vsync period", w + k, PAL_FRAME_CLKS);
    endtask

    task automatic csync_merge();
        int run;
        int long_runs;
        int long_len;
        int vsync_bad;
        run       = 0;
        long_runs = 0;
        long_len  = 0;
        vsync_bad = 0;
        restart(chip_6569r3, 1'b0, 1'b0, 1'b1);
        rand_bit(hpolarity);
        rand_bit(vpolarity);
        for (int n = 0; n < PAL_FRAME_CLKS; n++) begin
            @(negedge clk_dot4x);
            if (vsync !== 1'b0)
                vsync_bad++;
            if (sync_pulse(1'b0)) begin
                run++;
            end else begin
                if (run > 2 * 504) begin // longer than a line, so the merged vsync
                    long_runs++;
                    long_len = run;
                end
                run = 0;
            end
        end
        check_int("csync vsync high clocks", vsync_bad, 0);
        check_int("csync long pulses per frame", long_runs, 1);
        check_int("csync long pulse width", long_len, (2 * 291 - 2 * 289) * 2 * 504 + 121);
    endtask

    // pixel_out and half_bright, sampled once per output line inside active video
    task automatic line_buffer_replay();
        int   k;
        int   exp_color;
        int   act_lines;
        logic act, hb, prev_act, prev_hb;
        logic [3:0] pix;
        raster_y_t y;
        act_lines = 0;
        prev_act  = 1'b0;
        prev_hb   = 1'b0;
        restart(chip_6567r8, 1'b0, 1'b0, 1'b0);
        hpolarity = 1'b1;
        vpolarity = 1'b1;
        for (int line = 0; line < 2 * 263 + 4; line++) begin
            wait_rise(1'b0, 4 * 520 + 8, k);
            check_int("active at hsync start", int'(active), 0); // inside hblank
            repeat (2 * 80 + 100 - 2 * 10) @(negedge clk_dot4x); // h_count = ha_sta + 100
            act = active;
            hb  = half_bright;
            pix = pixel_out;
            y   = raster_y;
            if (line >= 4) begin // both buffers hold a whole line by now
                if (act) begin
                    act_lines++;
                    exp_color = (y == 0) ? (263 - 1) % 16 : (int'(y) - 1) % 16;
                    check_int("pixel_out", int'(pix), exp_color);
                    if (prev_act) begin
                        checks++;
                        if (hb == prev_hb) begin
                            errors++;
                            $display("[ERROR] %0t: half_bright %b did not alternate", $time, hb);
                        end
                    end
                end
                if (!prev_act)
                    check_int("half_bright after blank line", int'(hb), 0);
            end
            prev_act = act;
            prev_hb  = hb;
        end
        // 26 blanked lines out of 526 in a doubled 6567R8 frame
        check_int("active lines per frame", act_lines, 2 * 263 - (2 * 24 - 2 * 11));
    endtask

    task automatic native_x_at_origin();
        restart(chip_6569r3, 1'b0, 1'b0, 1'b0);
        hpolarity = 1'b1;
        while (raster_y != 9'd100)
            @(posedge clk_dot4x);
        #1;
        native_x = 1'b1; // mid frame, held off until the origin
        measure_line(2 * 504, 2 * (70 - 10) + 1, "before origin");
        while (!(raster_y == 9'd0 && raster_x == 10'd1))
            @(posedge clk_dot4x);
        #1;
        measure_line(2 * 504, 2 * (70 - 10 + 1), "after origin");
    endtask

    initial begin
        rst          = 1'b1;
        dot_rising   = 4'b0001;
        raster_x     = '0;
        raster_y     = '0;
        pixel_in     = '0;
        native_x     = 1'b0;
        native_y     = 1'b0;
        chip         = chip_6569r3;
        hpolarity    = 1'b1;
        vpolarity    = 1'b1;
        enable_csync = 1'b0;
        sub          = 2'd0;
        errors       = 0;
        checks       = 0;
        lfsr         = 8'd41;

        hsync_per_chip();
        vsync_per_frame();
        csync_merge();
        line_buffer_replay();
        native_x_at_origin();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/vga_scan_doubler.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_scan_doubler #(
    parameter int COLOR_WIDTH = 4
) (
    input  wire                          clk_dot4x,
    input  wire                          rst,
    input  wire [3:0]                    dot_rising,
    input  wire vga_scan_pkg::raster_x_t raster_x,
    input  wire vga_scan_pkg::raster_y_t raster_y,
    input  wire [COLOR_WIDTH-1:0]        pixel_in,
    input  wire                          native_x,
    input  wire                          native_y,
    input  wire vga_scan_pkg::chip_t     chip,
    input  wire                          hpolarity,
    input  wire                          vpolarity,
    input  wire                          enable_csync,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         active,
    output logic [COLOR_WIDTH-1:0]       pixel_out,
    output logic                         half_bright
);
    import vga_scan_pkg::*;

    chip_t   mode_chip;     // latched at reset and raster origin
    logic    mode_native_x;
    logic    mode_native_y;
    hcount_t h_count;
    vcount_t v_count;
    hcount_t max_width;
    vcount_t max_height;
    hcount_t ha_end, hs_sta, hs_end, ha_sta;
    vcount_t va_end, vs_sta, vs_end, va_sta;
    logic    line_visible;  // vertical active term, feeds half_bright

    scan_counter u_counter (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .native_x      (native_x),
        .native_y      (native_y),
        .chip          (chip),
        .max_width     (max_width),
        .max_height    (max_height),
        .line_visible  (line_visible),
        .mode_chip     (mode_chip),
        .mode_native_x (mode_native_x),
        .mode_native_y (mode_native_y),
        .h_count       (h_count),
        .v_count       (v_count),
        .half_bright   (half_bright)
    );

    scan_timing_table u_table (
        .mode_chip     (mode_chip),
        .mode_native_x (mode_native_x),
        .mode_native_y (mode_native_y),
        .max_width     (max_width),
        .max_height    (max_height),
        .ha_end        (ha_end),
        .hs_sta        (hs_sta),
        .hs_end        (hs_end),
        .ha_sta        (ha_sta),
        .va_end        (va_end),
        .vs_sta        (vs_sta),
        .vs_end        (vs_end),
        .va_sta        (va_sta)
    );

    sync_decoder u_sync (
        .h_count      (h_count),
        .v_count      (v_count),
        .ha_end       (ha_end),
        .hs_sta       (hs_sta),
        .hs_end       (hs_end),
        .ha_sta       (ha_sta),
        .va_end       (va_end),
        .vs_sta       (vs_sta),
        .vs_end       (vs_end),
        .va_sta       (va_sta),
        .mode_chip    (mode_chip),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .line_visible (line_visible)
    );

    // pixels run 2 clocks behind h_count
    line_store #(.COLOR_WIDTH(COLOR_WIDTH)) u_store (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_rising (dot_rising),
        .raster_x   (raster_x),
        .h_count    (h_count),
        .pixel_in   (pixel_in),
        .pixel_out  (pixel_out)
    );

endmodule

`default_nettype wire

/* verilog/sync_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_decoder (
    input  wire vga_scan_pkg::hcount_t h_count,
    input  wire vga_scan_pkg::vcount_t v_count,
    input  wire vga_scan_pkg::hcount_t ha_end,
    input  wire vga_scan_pkg::hcount_t hs_sta,
    input  wire vga_scan_pkg::hcount_t hs_end,
    input  wire vga_scan_pkg::hcount_t ha_sta,
    input  wire vga_scan_pkg::vcount_t va_end,
    input  wire vga_scan_pkg::vcount_t vs_sta,
    input  wire vga_scan_pkg::vcount_t vs_end,
    input  wire vga_scan_pkg::vcount_t va_sta,
    input  wire vga_scan_pkg::chip_t   mode_chip,
    input  wire                        hpolarity,
    input  wire                        vpolarity,
    input  wire                        enable_csync,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       active,
    output logic                       line_visible
);

    logic hsync_ah; // active-high pulses before polarity
    logic vsync_ah;
    logic csync_ah;
    logic hblank;
    logic vwindow;  // inside va_end..va_sta

    assign hsync_ah = (h_count >= hs_sta) && (h_count <= hs_end);

    // vsync starts and stops at the hsync position so the first and
    // last sync lines are whole lines
    assign vsync_ah = ((v_count == vs_sta && h_count >= hs_sta) || v_count > vs_sta) &&
                      ((v_count == vs_end && h_count < hs_end) || v_count < vs_end);

    assign csync_ah = hsync_ah | vsync_ah;

    // polarity 1 -> active high out
    assign hsync = enable_csync ? (hpolarity ? csync_ah : ~csync_ah)
                                : (hpolarity ? hsync_ah : ~hsync_ah);
    assign vsync = enable_csync ? 1'b0 : (vpolarity ? vsync_ah : ~vsync_ah);

    assign hblank = (h_count >= ha_end) && (h_count <= ha_sta);

    // same edge handling as vsync but against the ha boundaries
    assign vwindow = ((v_count == va_end && h_count >= ha_end) || v_count > va_end) &&
                     ((v_count == va_sta && h_count < ha_sta) || v_count < va_sta);

    // NTSC blanks inside the window, PAL blanks outside it (crosses line 0)
    assign line_visible = mode_chip[0] ? vwindow : ~vwindow;

    assign active = ~hblank & line_visible;

endmodule

`default_nettype wire

/* verilog/scan_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_counter (
    input  wire                          clk_dot4x,
    input  wire                          rst,
    input  wire vga_scan_pkg::raster_x_t raster_x,
    input  wire vga_scan_pkg::raster_y_t raster_y,
    input  wire                          native_x,
    input  wire                          native_y,
    input  wire vga_scan_pkg::chip_t     chip,
    input  wire vga_scan_pkg::hcount_t   max_width,
    input  wire vga_scan_pkg::vcount_t   max_height,
    input  wire                          line_visible,
    output vga_scan_pkg::chip_t          mode_chip,
    output logic                         mode_native_x,
    output logic                         mode_native_y,
    output vga_scan_pkg::hcount_t        h_count,
    output vga_scan_pkg::vcount_t        v_count,
    output logic                         half_bright
);

    logic [1:0] ff;      // phase within one native dot (4 clocks)
    logic       advance; // counters step on this clock
    logic       origin;  // native raster is at (0,0)
    logic       x_mode_change;

    // mode   | advance on ff | step
    // 2x 2y  | 0,1,2,3       | 1
    // one 1x | 1,3           | 2
    // 1x 1y  | 1             | 4
    always_comb begin
        if (!mode_native_x && !mode_native_y)
            advance = 1'b1;
        else if (mode_native_x && mode_native_y)
            advance = (ff == 2'd1);
        else
            advance = ff[0]; // odd phases
    end

    assign origin = (raster_x == '0) && (raster_y == '0);

    // new line length could leave h_count past the end, restart the line instead
    assign x_mode_change = (chip != mode_chip) || (native_x != mode_native_x);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ff            <= 2'd1;
            h_count       <= '0;
            v_count       <= '0;
            half_bright   <= 1'b0;
            mode_chip     <= chip;
            mode_native_x <= native_x;
            mode_native_y <= native_y;
        end else begin
            ff <= ff + 2'd1;
            if (advance) begin
                if (h_count < max_width) begin
                    h_count <= h_count + 11'd1;
                end else begin
                    h_count <= '0; // end of output line
                    if (v_count < max_height)
                        v_count <= v_count + 10'd1;
                    else
                        v_count <= '0;
                    // alternate dim lines only through the visible area
                    half_bright <= line_visible ? ~half_bright : 1'b0;
                end
            end
            if (origin) begin
                v_count       <= max_height; // wraps to 0 on the next line end
                mode_chip     <= chip;
                mode_native_x <= native_x;
                mode_native_y <= native_y;
                if (x_mode_change)
                    h_count <= '0;
            end
        end
    end

    // line limit comes from the timing table, so check it against the counter here
    a_h_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
        h_count <= max_width);

    // phase and counters sit at their start values while reset holds
    a_ff_hold: assert property (@(posedge clk_dot4x)
        rst |=> (ff == 2'd1) && (h_count == '0) && (v_count == '0));

endmodule

`default_nettype wire

/* verilog/scan_timing_table.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_timing_table (
    input  wire vga_scan_pkg::chip_t mode_chip,
    input  wire                      mode_native_x,
    input  wire                      mode_native_y,
    output vga_scan_pkg::hcount_t    max_width,
    output vga_scan_pkg::vcount_t    max_height,
    output vga_scan_pkg::hcount_t    ha_end,
    output vga_scan_pkg::hcount_t    hs_sta,
    output vga_scan_pkg::hcount_t    hs_end,
    output vga_scan_pkg::hcount_t    ha_sta,
    output vga_scan_pkg::vcount_t    va_end,
    output vga_scan_pkg::vcount_t    vs_sta,
    output vga_scan_pkg::vcount_t    vs_end,
    output vga_scan_pkg::vcount_t    va_sta
);
    import vga_scan_pkg::*;

    // native (1x) values for the selected chip
    hcount_t base_ha_end, base_hs_sta, base_hs_end, base_ha_sta;
    vcount_t base_va_end, base_vs_sta, base_vs_end, base_va_sta;
    hcount_t base_width;
    vcount_t base_height;

    always_comb begin
        base_ha_end = NTSC_HA_END; // horizontal is the same for both NTSC parts
        base_hs_sta = NTSC_HS_STA;
        base_hs_end = NTSC_HS_END;
        base_ha_sta = NTSC_HA_STA;
        base_va_end = NTSC_VA_END;
        base_vs_sta = NTSC_VS_STA;
        base_vs_end = NTSC_VS_END;
        base_va_sta = NTSC_VA_STA;
        base_width  = R56A_WIDTH;
        base_height = R56A_HEIGHT;
        case (mode_chip)
            chip_6569r1, chip_6569r3: begin
                base_ha_end = PAL_HA_END;
                base_hs_sta = PAL_HS_STA;
                base_hs_end = PAL_HS_END;
                base_ha_sta = PAL_HA_STA;
                base_va_end = PAL_VA_END; // inverted window, see sync_decoder
                base_vs_sta = PAL_VS_STA;
                base_vs_end = PAL_VS_END;
                base_va_sta = PAL_VA_STA;
                base_width  = PAL_WIDTH;
                base_height = PAL_HEIGHT;
            end
            chip_6567r8: begin
                base_width  = R8_WIDTH;
                base_height = R8_HEIGHT;
            end
            default: ; // 6567R56A keeps the defaults above
        endcase
    end

    // doubled axis -> every boundary and the line/frame length scale by 2
    assign ha_end = mode_native_x ? base_ha_end : base_ha_end << 1;
    assign hs_sta = mode_native_x ? base_hs_sta : base_hs_sta << 1;
    assign hs_end = mode_native_x ? base_hs_end : base_hs_end << 1;
    assign ha_sta = mode_native_x ? base_ha_sta : base_ha_sta << 1;
    assign va_end = mode_native_y ? base_va_end : base_va_end << 1;
    assign vs_sta = mode_native_y ? base_vs_sta : base_vs_sta << 1;
    assign vs_end = mode_native_y ? base_vs_end : base_vs_end << 1;
    assign va_sta = mode_native_y ? base_va_sta : base_va_sta << 1;

    // limits are inclusive, last count before wrap
    assign max_width  = (mode_native_x ? base_width : base_width << 1) - 11'd1;
    assign max_height = (mode_native_y ? base_height : base_height << 1) - 10'd1;

endmodule

`default_nettype wire

/* verilog/line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module line_store #(
    parameter int COLOR_WIDTH = 4
) (
    input  wire                          clk_dot4x,
    input  wire                          rst,
    input  wire [3:0]                    dot_rising,
    input  wire vga_scan_pkg::raster_x_t raster_x,
    input  wire vga_scan_pkg::hcount_t   h_count,
    input  wire [COLOR_WIDTH-1:0]        pixel_in,
    output logic [COLOR_WIDTH-1:0]       pixel_out
);
    import vga_scan_pkg::*;

    logic                       bank;   // 1 -> fill ram0, read ram1
    logic                       bank_q; // bank as seen by the ram read a clock ago
    logic                       we0, we1;
    logic [LINE_ADDR_WIDTH-1:0] wr_addr, rd_addr;
    logic [LINE_ADDR_WIDTH-1:0] addr0, addr1;
    logic [COLOR_WIDTH-1:0]     dout0, dout1;

    assign wr_addr = LINE_ADDR_WIDTH'(raster_x); // native x, held for 4 clocks
    assign rd_addr = LINE_ADDR_WIDTH'(h_count);

    assign we0   = bank;
    assign we1   = ~bank;
    assign addr0 = bank ? wr_addr : rd_addr;
    assign addr1 = bank ? rd_addr : wr_addr;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            bank      <= 1'b0;
            bank_q    <= 1'b0;
            pixel_out <= '0;
        end else begin
            if (dot_rising[1] && raster_x == '0)
                bank <= ~bank; // new native line, swap fill and read
            bank_q    <= bank;
            pixel_out <= bank_q ? dout1 : dout0; // second stage of read latency
        end
    end

    line_ram #(.ADDR_WIDTH(LINE_ADDR_WIDTH), .DATA_WIDTH(COLOR_WIDTH)) u_ram0 (
        .clk_dot4x (clk_dot4x),
        .we        (we0),
        .addr      (addr0),
        .din       (pixel_in),
        .dout      (dout0)
    );

    line_ram #(.ADDR_WIDTH(LINE_ADDR_WIDTH), .DATA_WIDTH(COLOR_WIDTH)) u_ram1 (
        .clk_dot4x (clk_dot4x),
        .we        (we1),
        .addr      (addr1),
        .din       (pixel_in),
        .dout      (dout1)
    );

    a_one_writer: assert property (@(posedge clk_dot4x) disable iff (rst)
        !(we0 && we1));

endmodule

`default_nettype wire

/* verilog/line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_ram #(
    parameter int ADDR_WIDTH = 11,
    parameter int DATA_WIDTH = 4
) (
    input  wire                   clk_dot4x,
    input  wire                   we,
    input  wire [ADDR_WIDTH-1:0]  addr,
    input  wire [DATA_WIDTH-1:0]  din,
    output logic [DATA_WIDTH-1:0] dout
);

    // one raster line of color indexes
    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk_dot4x) begin
        if (we)
            mem[addr] <= din;
        dout <= mem[addr]; // old data on a write clock
    end

endmodule

`default_nettype wire

/* verilog/vga_scan_pkg.sv */
`default_nettype none

package vga_scan_pkg;

    // chip select codes, bit 0 marks a PAL part
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6569r3   = 2'd1,
        chip_6567r56a = 2'd2,
        chip_6569r1   = 2'd3
    } chip_t;

    typedef logic [10:0] hcount_t;   // output x, up to 2x native width
    typedef logic [9:0]  vcount_t;   // output y, up to 2x native height
    typedef logic [9:0]  raster_x_t; // native raster x from the chip
    typedef logic [8:0]  raster_y_t; // native raster y from the chip
    typedef logic [3:0]  color_t;    // color index

    // line ram depth covers a doubled line of the widest chip
    localparam int LINE_ADDR_WIDTH = 11;

    // PAL 6569, blanking crosses line 0 so the va window is inverted
    localparam hcount_t PAL_HA_END = 11'd0;
    localparam hcount_t PAL_HS_STA = 11'd10;  // front porch 10
    localparam hcount_t PAL_HS_END = 11'd70;  // sync 60
    localparam hcount_t PAL_HA_STA = 11'd90;  // back porch 20
    localparam vcount_t PAL_VA_END = 10'd20;  // really where active starts
    localparam vcount_t PAL_VA_STA = 10'd284; // really where active ends
    localparam vcount_t PAL_VS_STA = 10'd289;
    localparam vcount_t PAL_VS_END = 10'd291;
    localparam hcount_t PAL_WIDTH  = 11'd504;
    localparam vcount_t PAL_HEIGHT = 10'd312;

    // NTSC boundaries, shared by 6567R8 and 6567R56A
    localparam hcount_t NTSC_HA_END = 11'd0;
    localparam hcount_t NTSC_HS_STA = 11'd10;
    localparam hcount_t NTSC_HS_END = 11'd70;
    localparam hcount_t NTSC_HA_STA = 11'd80;
    localparam vcount_t NTSC_VA_END = 10'd11;
    localparam vcount_t NTSC_VS_STA = 10'd19; // front porch 8
    localparam vcount_t NTSC_VS_END = 10'd22; // sync 3 lines
    localparam vcount_t NTSC_VA_STA = 10'd24;

    localparam hcount_t R8_WIDTH    = 11'd520;
    localparam vcount_t R8_HEIGHT   = 10'd263;
    localparam hcount_t R56A_WIDTH  = 11'd512;
    localparam vcount_t R56A_HEIGHT = 10'd262;

endpackage

`default_nettype wire
